/* logic/fl_avail_counter.sv */
// Availability counter: tracks free entries and reports them clamped to DP_NUM
`timescale 1ns/1ps
`include "fl_cfg.svh"

module fl_avail_counter
    import fl_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                exception_i,
    input  dp_count_t                           dp_num_i,
    fl_retire_if.sink                           retire,
    input  logic        [`FL_ENTRY_NUM-1:0]     entry_free_i,
    input  thread_idx_t [`FL_ENTRY_NUM-1:0]     entry_thread_i,
    output dp_count_t                           avail_o
);

    // In-flight entries per thread
    fl_count_t [`FL_THREAD_NUM-1:0] inflight_cnt;
    // Live retire slots per thread, zero tag excluded
    fl_count_t [`FL_THREAD_NUM-1:0] retire_cnt;
    // Registered free count
    fl_count_t                      avail_q;
    fl_count_t                      avail_d;

    // ==============================
    // Per-thread counts
    // ==============================

    always_comb begin
        for (int t = 0; t < `FL_THREAD_NUM; t++) begin
            inflight_cnt[t] = '0;
            for (int i = 0; i < `FL_ENTRY_NUM; i++) begin
                if (!entry_free_i[i] && (entry_thread_i[i] == thread_idx_t'(t))) begin
                    inflight_cnt[t] = inflight_cnt[t] + fl_count_t'(1);
                end
            end
        end
    end

    always_comb begin
        for (int t = 0; t < `FL_THREAD_NUM; t++) begin
            retire_cnt[t] = '0;
            for (int s = 0; s < `FL_RT_NUM; s++) begin
                // Zero register never goes back on the list
                if ((rt_count_t'(s) < retire.rt_num[t])
                    && (retire.rt_tag[t][s] != phys_tag_t'(`FL_ZERO_TAG))) begin
                    retire_cnt[t] = retire_cnt[t] + fl_count_t'(1);
                end
            end
        end
    end

    // ==============================
    // Next count
    // ==============================

    // Rollback returns the whole thread, else just its retires
    always_comb begin
        avail_d = avail_q;
        for (int t = 0; t < `FL_THREAD_NUM; t++) begin
            if (retire.br_mis[t]) begin
                avail_d = avail_d + inflight_cnt[t];
            end else begin
                avail_d = avail_d + retire_cnt[t];
            end
        end
        avail_d = avail_d - fl_count_t'(dp_num_i);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || exception_i) begin
            avail_q <= fl_count_t'(`FL_ENTRY_NUM);
        end else begin
            avail_q <= avail_d;
        end
    end

    // Clamp to what one cycle can consume
    assign avail_o = (avail_q > fl_count_t'(`FL_DP_NUM)) ? dp_count_t'(`FL_DP_NUM)
                                                         : dp_count_t'(avail_q);

endmodule

/* logic/fl_cfg.svh */
// Free list configuration: entry, thread, dispatch and retire sizing
`ifndef FL_CFG_SVH
`define FL_CFG_SVH

// ==============================
// Array sizing
// ==============================

// Free list depth
`define FL_ENTRY_NUM    8
// Hardware threads sharing the list
`define FL_THREAD_NUM   2
// Max tags handed out per cycle
`define FL_DP_NUM       2
// Retire slots per thread per cycle
`define FL_RT_NUM       2

// ==============================
// Register file
// ==============================

// Architectural registers per thread
`define FL_ARCH_REG_NUM 8
// Physical tag width
`define FL_TAG_WIDTH    5
// Hard-wired zero register, never freed
`define FL_ZERO_TAG     0
// First tag past the architectural mapping
// Zero register shared by all threads
`define FL_START_TAG    (`FL_THREAD_NUM * `FL_ARCH_REG_NUM - `FL_THREAD_NUM + 1)

`endif

/* logic/fl_dispatch_select.sv */
// Dispatch select with chained priority encoders picking the lowest free entries
`timescale 1ns/1ps
`include "fl_cfg.svh"

module fl_dispatch_select
    import fl_pkg::*;
(
    input  dp_count_t   dp_num_i,
    fl_grant_if.select  grant
);

    // ==============================
    // Lowest set bit encoder
    // ==============================

    // Scanning from the top down so the LSB wins
    function automatic fl_idx_t lowest_idx(input logic [`FL_ENTRY_NUM-1:0] bits);
        fl_idx_t idx;
        idx = '0;
        for (int i = `FL_ENTRY_NUM - 1; i >= 0; i--) begin
            if (bits[i]) begin
                idx = fl_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // ==============================
    // Encoder chain
    // ==============================

    genvar k;
    for (k = 0; k < `FL_DP_NUM; k++) begin : g_stage
        // Entries still open to this stage
        logic [`FL_ENTRY_NUM-1:0] avail_bits;
        fl_idx_t                  pick_idx;
        logic                     pick_hit;

        if (k == 0) begin : g_head
            // First stage sees the whole free mask
            assign avail_bits = grant.free_mask;
        end else begin : g_chain
            // Knock out the previous stage's pick
            assign avail_bits = g_stage[k-1].avail_bits
                & ~({{(`FL_ENTRY_NUM-1){1'b0}}, 1'b1} << g_stage[k-1].pick_idx);
        end

        assign pick_idx = lowest_idx(avail_bits);
        assign pick_hit = |avail_bits;

        // Index reflects the candidate even without a request
        assign grant.grant_idx[k] = pick_idx;

        // Slot k only counts when the dispatcher asked for it
        assign grant.grant_valid[k] = pick_hit && (dp_count_t'(k) < dp_num_i);
    end

    // ==============================
    // Per-entry dispatch select
    // ==============================

    always_comb begin
        grant.dp_sel = '0;
        for (int s = 0; s < `FL_DP_NUM; s++) begin
            // Picks are distinct by construction of the chain
            if (grant.grant_valid[s]) begin
                grant.dp_sel[grant.grant_idx[s]] = 1'b1;
            end
        end
    end

endmodule

/* logic/fl_entry_array.sv */
// Free list entry storage with dispatch, retire, rollback and flush updates
`timescale 1ns/1ps
`include "fl_cfg.svh"

module fl_entry_array
    import fl_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                exception_i,
    input  thread_idx_t                         dp_thread_i,
    fl_retire_if.sink                           retire,
    fl_grant_if.array                           grant,
    output logic        [`FL_ENTRY_NUM-1:0]     entry_free_o,
    output thread_idx_t [`FL_ENTRY_NUM-1:0]     entry_thread_o,
    output phys_tag_t   [`FL_DP_NUM-1:0]        dp_tag_o
);

    // ==============================
    // Entry state
    // ==============================

    // 1 = free, 0 = in flight
    logic        [`FL_ENTRY_NUM-1:0] entry_free;
    // Owner of an in-flight entry
    thread_idx_t [`FL_ENTRY_NUM-1:0] entry_thread;
    // Tag held by the entry
    phys_tag_t   [`FL_ENTRY_NUM-1:0] entry_tag;

    // Retire match per entry, and the tag it brings back
    logic        [`FL_ENTRY_NUM-1:0] rt_hit;
    phys_tag_t   [`FL_ENTRY_NUM-1:0] rt_old;

    // ==============================
    // Retire match
    // ==============================

    // Only slots of the entry's owner are compared
    always_comb begin
        for (int i = 0; i < `FL_ENTRY_NUM; i++) begin
            rt_hit[i] = 1'b0;
            rt_old[i] = entry_tag[i];
            for (int s = 0; s < `FL_RT_NUM; s++) begin
                // Slots below rt_num are live
                if ((rt_count_t'(s) < retire.rt_num[entry_thread[i]])
                    && (entry_tag[i] == retire.rt_tag[entry_thread[i]][s])) begin
                    rt_hit[i] = 1'b1;
                    rt_old[i] = retire.rt_tag_old[entry_thread[i]][s];
                end
            end
        end
    end

    // ==============================
    // Entry update
    // ==============================

    always_ff @(posedge clk_i) begin
        if (reset_i || exception_i) begin
            // Back to the initial tag window, all free
            for (int i = 0; i < `FL_ENTRY_NUM; i++) begin
                entry_free[i]   <= 1'b1;
                entry_thread[i] <= '0;
                entry_tag[i]    <= phys_tag_t'(`FL_START_TAG + i);
            end
        end else begin
            for (int i = 0; i < `FL_ENTRY_NUM; i++) begin
                if (!entry_free[i]) begin
                    if (retire.br_mis[entry_thread[i]]) begin
                        // Rollback wins over plain retire
                        entry_free[i] <= 1'b1;
                        // Same-cycle retire still swaps in the old tag
                        if (rt_hit[i]) begin
                            entry_tag[i] <= rt_old[i];
                        end
                    end else if (rt_hit[i]) begin
                        // Normal retire: old mapping becomes free
                        entry_free[i] <= 1'b1;
                        entry_tag[i]  <= rt_old[i];
                    end
                end else if (grant.dp_sel[i]) begin
                    // Picked for dispatch, now in flight
                    entry_free[i]   <= 1'b0;
                    entry_thread[i] <= dp_thread_i;
                end
            end
        end
    end

    // ==============================
    // Outputs
    // ==============================

    assign grant.free_mask = entry_free;
    assign entry_free_o    = entry_free;
    assign entry_thread_o  = entry_thread;

    // Tag of each slot's candidate entry
    always_comb begin
        for (int s = 0; s < `FL_DP_NUM; s++) begin
            dp_tag_o[s] = entry_tag[grant.grant_idx[s]];
        end
    end

endmodule

/* logic/fl_if.sv */
// Free list interfaces for retire/rollback and dispatch grant traffic
`timescale 1ns/1ps
`include "fl_cfg.svh"

// Retire slots and mispredict flags, per thread
interface fl_retire_if
    import fl_pkg::*;
();

    // Valid slot count per thread
    rt_count_t [`FL_THREAD_NUM-1:0]                  rt_num;
    // Retiring tag, matched against in-flight entries
    phys_tag_t [`FL_THREAD_NUM-1:0][`FL_RT_NUM-1:0]  rt_tag;
    // Tag released back to the list
    phys_tag_t [`FL_THREAD_NUM-1:0][`FL_RT_NUM-1:0]  rt_tag_old;
    // Rollback request, one bit per thread
    logic      [`FL_THREAD_NUM-1:0]                  br_mis;

    modport source (output rt_num, output rt_tag, output rt_tag_old, output br_mis);
    modport sink   (input rt_num, input rt_tag, input rt_tag_old, input br_mis);

endinterface

// Free entries in, selected entries out
interface fl_grant_if
    import fl_pkg::*;
();

    // One bit per free entry
    logic    [`FL_ENTRY_NUM-1:0]      free_mask;
    // Per-entry one-hot of this cycle's dispatch picks
    logic    [`FL_ENTRY_NUM-1:0]      dp_sel;
    // Entry picked by each dispatch slot
    fl_idx_t [`FL_DP_NUM-1:0]         grant_idx;
    // Slot found an entry and was requested
    logic    [`FL_DP_NUM-1:0]         grant_valid;

    modport array  (output free_mask, input dp_sel, input grant_idx);
    modport select (input free_mask, output dp_sel, output grant_idx, output grant_valid);

endinterface

/* logic/fl_pkg.sv */
// Free list types shared by the RTL blocks and the testbench
`include "fl_cfg.svh"

package fl_pkg;

    // ==============================
    // Tags and indices
    // ==============================

    // Physical register tag
    typedef logic [`FL_TAG_WIDTH-1:0] phys_tag_t;

    // Free list entry index
    typedef logic [$clog2(`FL_ENTRY_NUM)-1:0] fl_idx_t;

    // Thread number
    typedef logic [$clog2(`FL_THREAD_NUM)-1:0] thread_idx_t;

    // ==============================
    // Counts
    // ==============================

    // Entry count, 0 to FL_ENTRY_NUM inclusive
    typedef logic [$clog2(`FL_ENTRY_NUM+1)-1:0] fl_count_t;

    // Dispatch count, 0 to FL_DP_NUM
    typedef logic [$clog2(`FL_DP_NUM+1)-1:0] dp_count_t;

    // Retire count per thread, 0 to FL_RT_NUM
    typedef logic [$clog2(`FL_RT_NUM+1)-1:0] rt_count_t;

endpackage

/* logic/fl_top.sv */
// Free list top: two-thread physical tag allocator with retire and rollback
`timescale 1ns/1ps
`include "fl_cfg.svh"

module fl_top
    import fl_pkg::*;
(
    input  logic                                            clk_i,
    input  logic                                            reset_i,
    input  logic                                            exception_i,
    // Dispatch request, bounded by avail_o
    input  dp_count_t                                       dp_num_i,
    input  thread_idx_t                                     dp_thread_i,
    // Retire slots per thread
    input  rt_count_t [`FL_THREAD_NUM-1:0]                  rt_num_i,
    input  phys_tag_t [`FL_THREAD_NUM-1:0][`FL_RT_NUM-1:0]  rt_tag_i,
    input  phys_tag_t [`FL_THREAD_NUM-1:0][`FL_RT_NUM-1:0]  rt_tag_old_i,
    // Mispredict, one bit per thread
    input  logic      [`FL_THREAD_NUM-1:0]                  br_mis_i,
    // Availability clamped to DP_NUM
    output dp_count_t                                       avail_o,
    // Candidate tags, lowest free entry first
    output phys_tag_t [`FL_DP_NUM-1:0]                      dp_tag_o
);

    // ==============================
    // Internal buses
    // ==============================

    fl_retire_if rt_bus ();
    fl_grant_if  gr_bus ();

    // Entry state seen by the counter
    logic        [`FL_ENTRY_NUM-1:0] entry_free;
    thread_idx_t [`FL_ENTRY_NUM-1:0] entry_thread;

    // Pack retire and rollback ports onto the bus
    assign rt_bus.rt_num     = rt_num_i;
    assign rt_bus.rt_tag     = rt_tag_i;
    assign rt_bus.rt_tag_old = rt_tag_old_i;
    assign rt_bus.br_mis     = br_mis_i;

    // ==============================
    // Blocks
    // ==============================

    // Combinational pick of the lowest free entries
    fl_dispatch_select u_select (
        .dp_num_i       (dp_num_i),
        .grant          (gr_bus.select)
    );

    // Entry storage and tag mux
    fl_entry_array u_array (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .exception_i    (exception_i),
        .dp_thread_i    (dp_thread_i),
        .retire         (rt_bus.sink),
        .grant          (gr_bus.array),
        .entry_free_o   (entry_free),
        .entry_thread_o (entry_thread),
        .dp_tag_o       (dp_tag_o)
    );

    // Running free count
    fl_avail_counter u_counter (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .exception_i    (exception_i),
        .dp_num_i       (dp_num_i),
        .retire         (rt_bus.sink),
        .entry_free_i   (entry_free),
        .entry_thread_i (entry_thread),
        .avail_o        (avail_o)
    );

endmodule

/* project.f */
+incdir+logic
logic/fl_pkg.sv
logic/fl_if.sv
logic/fl_dispatch_select.sv
logic/fl_entry_array.sv
logic/fl_avail_counter.sv
logic/fl_top.sv
tests/fl_properties.sv
tests/fl_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the free list simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module fl_tb -f project.f --Mdir obj_dir -o fl_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

/* tests/fl_cases.txt */
# name exc dp_num dp_thr rt_num0 tag00 old00 tag01 old01 rt_num1 tag10 old10 tag11 old11
# ... br_mis exp_avail exp_tag0 exp_tag1 (decimal, expected values hold one cycle later)
idle           0 0 0  0  0 0  0 0  0 0 0 0 0  0  2 15 16
dp0_a          0 2 0  0  0 0  0 0  0 0 0 0 0  0  2 17 18
dp0_b          0 2 0  0  0 0  0 0  0 0 0 0 0  0  2 19 20
dp0_c          0 2 0  0  0 0  0 0  0 0 0 0 0  0  2 21 22
dp0_d          0 1 0  0  0 0  0 0  0 0 0 0 0  0  1 22 15
dp0_e          0 1 0  0  0 0  0 0  0 0 0 0 0  0  0 15 15
idle_full      0 0 0  0  0 0  0 0  0 0 0 0 0  0  0 15 15
rt_one         0 0 0  1 17 3  0 0  0 0 0 0 0  0  1  3 15
rt_zero        0 0 0  1  0 9  0 0  0 0 0 0 0  0  1  3 15
rt_two         0 0 0  2 15 4 20 5  0 0 0 0 0  0  2  4  3
exc_flush      1 0 0  0  0 0  0 0  0 0 0 0 0  0  2 15 16
dp_t0          0 2 0  0  0 0  0 0  0 0 0 0 0  0  2 17 18
dp_t1          0 2 1  0  0 0  0 0  0 0 0 0 0  0  2 19 20
dp_t0_2        0 1 0  0  0 0  0 0  0 0 0 0 0  0  2 20 21
dp_t1_2        0 2 1  0  0 0  0 0  0 0 0 0 0  0  1 22 15
br_mis_t1      0 0 0  0  0 0  0 0  0 0 0 0 0  2  2 17 18
dp_after_mis   0 2 0  0  0 0  0 0  0 0 0 0 0  0  2 20 21
dp_after_mis_2 0 2 0  0  0 0  0 0  0 0 0 0 0  0  1 22 15
rt_t0          0 0 0  1 16 7  0 0  0 0 0 0 0  0  2  7 22
dp_rt          0 2 1  1 18 6  0 0  0 0 0 0 0  0  1  6 15
br_mis_both    0 0 0  0  0 0  0 0  0 0 0 0 0  3  2 15  7
exc_final      1 0 0  0  0 0  0 0  0 0 0 0 0  0  2 15 16
idle_end       0 0 0  0  0 0  0 0  0 0 0 0 0  0  2 15 16

/* tests/fl_properties.sv */
// Free list assertions: dispatch credit rule and free-entry bookkeeping
`timescale 1ns/1ps
`include "fl_cfg.svh"

module fl_properties
    import fl_pkg::*;
(
    input  logic                               clk_i,
    input  logic                               reset_i,
    input  logic                               exception_i,
    input  dp_count_t                          dp_num_i,
    input  rt_count_t [`FL_THREAD_NUM-1:0]     rt_num_i,
    input  logic      [`FL_THREAD_NUM-1:0]     br_mis_i,
    input  dp_count_t                          avail_o,
    input  logic      [`FL_ENTRY_NUM-1:0]      entry_free_i
);

    // Free entries in the array
    int free_cnt;
    assign free_cnt = $countones(entry_free_i);

    // ==============================
    // Credit rule
    // ==============================

    a_credit: assert property (@(posedge clk_i) disable iff (reset_i)
        dp_num_i <= avail_o)
        else $error("dispatch request above reported availability");

    // ==============================
    // Dispatch-only bookkeeping
    // ==============================

    // No retire, rollback or flush: only the grants leave the free pool
    a_dispatch_only: assert property (@(posedge clk_i) disable iff (reset_i)
        (!exception_i && (rt_num_i == '0) && (br_mis_i == '0))
        |=> (free_cnt == $past(free_cnt) - int'($past(dp_num_i))))
        else $error("free entry count did not drop by the dispatch count");

endmodule

bind fl_top fl_properties u_props (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .exception_i  (exception_i),
    .dp_num_i     (dp_num_i),
    .rt_num_i     (rt_num_i),
    .br_mis_i     (br_mis_i),
    .avail_o      (avail_o),
    .entry_free_i (entry_free)
);

/* tests/fl_tb.sv */
// Free list testbench driving case-file stimulus and checking availability and tags
`timescale 1ns/1ps
`include "fl_cfg.svh"

module fl_tb
    import fl_pkg::*;
();

    // Columns after the case name
    localparam int FIELD_NUM = 17;

    // Outputs expected straight after reset
    localparam int RESET_AVAIL = 2;
    localparam int RESET_TAG0  = 15;
    localparam int RESET_TAG1  = 16;

    logic                                            clk_i;
    logic                                            reset_i;
    logic                                            exception_i;
    dp_count_t                                       dp_num_i;
    thread_idx_t                                     dp_thread_i;
    rt_count_t [`FL_THREAD_NUM-1:0]                  rt_num_i;
    phys_tag_t [`FL_THREAD_NUM-1:0][`FL_RT_NUM-1:0]  rt_tag_i;
    phys_tag_t [`FL_THREAD_NUM-1:0][`FL_RT_NUM-1:0]  rt_tag_old_i;
    logic      [`FL_THREAD_NUM-1:0]                  br_mis_i;
    dp_count_t                                       avail_o;
    phys_tag_t [`FL_DP_NUM-1:0]                      dp_tag_o;

    // Parsed cases in flat field storage
    string name_q[$];
    int    field_q[$];
    int    err_cnt = 0;
    int    cycle_cnt = 0;
    int    cycle_limit = 20;

    fl_top DUT (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .exception_i  (exception_i),
        .dp_num_i     (dp_num_i),
        .dp_thread_i  (dp_thread_i),
        .rt_num_i     (rt_num_i),
        .rt_tag_i     (rt_tag_i),
        .rt_tag_old_i (rt_tag_old_i),
        .br_mis_i     (br_mis_i),
        .avail_o      (avail_o),
        .dp_tag_o     (dp_tag_o)
    );

    // ==============================
    // Clock and timeout
    // ==============================

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    initial begin
        forever begin
            @(posedge clk_i);
            cycle_cnt++;
            if (cycle_cnt > cycle_limit) begin
                $display("Timeout: run went past %0d cycles", cycle_limit);
                abort_run();
            end
        end
    end

    // ==============================
    // Helpers
    // ==============================

    task automatic abort_run();
        err_cnt++;
        $display("Some tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_avail(input string name, input dp_count_t expected,
                               input dp_count_t actual);
        if (actual !== expected) begin
            $display("FAILED %s avail_o expected %0d actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_tag(input string name, input int slot, input phys_tag_t expected,
                             input phys_tag_t actual);
        if (actual !== expected) begin
            $display("FAILED %s dp_tag_o[%0d] expected %0d actual %0d",
                     name, slot, expected, actual);
            abort_run();
        end
    endtask

    // Skips comment and blank lines and sets the cycle budget
    task automatic load_cases();
        int    fd;
        int    rc;
        string line;
        string name;
        int    v[FIELD_NUM];
        fd = $fopen("tests/fl_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file tests/fl_cases.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
                rc = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                             name, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                             v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
                if (rc != FIELD_NUM + 1) begin
                    $display("Case file line has the wrong number of fields: %s", line);
                    abort_run();
                end
                name_q.push_back(name);
                for (int k = 0; k < FIELD_NUM; k++) begin
                    field_q.push_back(v[k]);
                end
            end
        end
        $fclose(fd);
        cycle_limit = 4 * name_q.size() + 20;
    endtask

    task automatic apply_idle();
        exception_i  = 1'b0;
        dp_num_i     = '0;
        dp_thread_i  = '0;
        rt_num_i     = '0;
        rt_tag_i     = '0;
        rt_tag_old_i = '0;
        br_mis_i     = '0;
    endtask

    // Field order is exc dp_num dp_thread, per-thread retire slots and br_mis
    task automatic drive_case(input int c);
        int b;
        int r;
        b = c * FIELD_NUM;
        // Dispatcher must stay inside the reported credit
        if (field_q[b+1] > int'(avail_o)) begin
            $display("Case %s asks for %0d tags while only %0d are available",
                     name_q[c], field_q[b+1], avail_o);
            abort_run();
        end
        exception_i = (field_q[b] != 0);
        dp_num_i    = dp_count_t'(field_q[b+1]);
        dp_thread_i = thread_idx_t'(field_q[b+2]);
        for (int t = 0; t < 2; t++) begin
            r = b + 3 + t * 5;
            rt_num_i[t] = rt_count_t'(field_q[r]);
            for (int s = 0; s < 2; s++) begin
                rt_tag_i[t][s]     = phys_tag_t'(field_q[r+1+2*s]);
                rt_tag_old_i[t][s] = phys_tag_t'(field_q[r+2+2*s]);
            end
        end
        br_mis_i = 2'(field_q[b+13]);
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        reset_i = 1'b1;
        apply_idle();
        load_cases();
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        // Reset contents visible straight away
        check_avail("reset_state", dp_count_t'(RESET_AVAIL), avail_o);
        check_tag("reset_state", 0, phys_tag_t'(RESET_TAG0), dp_tag_o[0]);
        check_tag("reset_state", 1, phys_tag_t'(RESET_TAG1), dp_tag_o[1]);
        for (int c = 0; c < name_q.size(); c++) begin
            drive_case(c);
            @(negedge clk_i);
            // Expected values describe the cycle after the case
            check_avail(name_q[c], dp_count_t'(field_q[c*FIELD_NUM+14]), avail_o);
            check_tag(name_q[c], 0, phys_tag_t'(field_q[c*FIELD_NUM+15]), dp_tag_o[0]);
            check_tag(name_q[c], 1, phys_tag_t'(field_q[c*FIELD_NUM+16]), dp_tag_o[1]);
        end
        apply_idle();
        @(negedge clk_i);
        if (err_cnt == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "errors were recorded");
        end
    end

endmodule
